//--- verilog.f
logic/lsu_pkg.sv
logic/lsu_sequencer.sv
logic/lsu_mem_if.sv
logic/lsu_data_ram.sv
logic/lsu_top.sv
bench/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -j 0 --top-module lsu_tb -f verilog.f \
   --Mdir obj_dir -o lsu_sim > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log
grep -q "^Test completed successfully$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- bench/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
   import lsu_pkg::*;

   localparam int RAM_WORDS      = 64;
   localparam int RAM_BYTES      = RAM_WORDS * 4;
   localparam int N_TABLE        = 24;
   localparam int N_RANDOM       = 200;
   localparam int TIMEOUT_CYCLES = (N_TABLE + N_RANDOM) * 80;

   typedef struct packed {
      mem_op_e     op;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] exp_rdata;
      logic        exp_mis;
   } vec_t;

   logic     i_clk;
   logic     i_rst;
   logic     i_req_valid;
   lsu_req_t i_req;
   logic     o_busy;
   logic     o_rsp_valid;
   lsu_rsp_t o_rsp;

   vec_t        table_q [N_TABLE];
   logic [7:0]  model_mem [RAM_BYTES];
   logic [31:0] rng;
   int          errors;
   int          checks;
   int          cycles = 0;

   lsu_top #(.RAM_WORDS(RAM_WORDS)) u_dut (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_req_valid (i_req_valid),
      .i_req       (i_req),
      .o_busy      (o_busy),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp       (o_rsp)
   );

   always #10 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: run still going after %0d cycles", cycles);
         $display("Test failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic vec_t make_vec(mem_op_e op, logic [31:0] addr, logic [31:0] wdata,
                                     logic [31:0] exp_rdata, logic exp_mis);
      vec_t v;
      v.op        = op;
      v.addr      = addr;
      v.wdata     = wdata;
      v.exp_rdata = exp_rdata;
      v.exp_mis   = exp_mis;
      return v;
   endfunction

   function automatic int access_bytes(mem_op_e op);
      case (op)
         LB, LBU, SB: return 1;
         LH, LHU, SH: return 2;
         default:     return 4;
      endcase
   endfunction

   function automatic logic writes_memory(mem_op_e op);
      return op inside {SB, SH, SW};
   endfunction

   // Little-endian byte model of the data RAM
   task automatic model_access(input mem_op_e op, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic mis);
      int          n;
      int          base;
      logic [31:0] raw;
      n     = access_bytes(op);
      base  = int'(addr[7:0]);
      raw   = 32'd0;
      rdata = 32'd0;
      mis   = (addr[1:0] & 2'(n - 1)) != 2'd0;
      if (!mis) begin
         for (int i = 0; i < n; i++) begin
            if (writes_memory(op)) begin
               model_mem[base + i] = wdata[8*i +: 8];
            end
            raw[8*i +: 8] = model_mem[base + i];
         end
         if (!writes_memory(op)) begin
            case (op)
               LB:      rdata = {{24{raw[7]}}, raw[7:0]};
               LH:      rdata = {{16{raw[15]}}, raw[15:0]};
               default: rdata = raw;
            endcase
         end
      end
   endtask

   task automatic fill_table();
      table_q[0]  = make_vec(SW,  32'h10, 32'h8765_4321, 32'h0000_0000, 1'b0);
      table_q[1]  = make_vec(LW,  32'h10, 32'h0000_0000, 32'h8765_4321, 1'b0);
      table_q[2]  = make_vec(SW,  32'h20, 32'h1122_3344, 32'h0000_0000, 1'b0);
      table_q[3]  = make_vec(SB,  32'h20, 32'h0000_00CD, 32'h0000_0000, 1'b0);
      table_q[4]  = make_vec(SB,  32'h21, 32'h0000_0055, 32'h0000_0000, 1'b0);
      table_q[5]  = make_vec(SB,  32'h22, 32'h0000_00EE, 32'h0000_0000, 1'b0);
      table_q[6]  = make_vec(SB,  32'h23, 32'hFFFF_FF80, 32'h0000_0000, 1'b0);
      table_q[7]  = make_vec(LW,  32'h20, 32'h0000_0000, 32'h80EE_55CD, 1'b0);
      table_q[8]  = make_vec(SH,  32'h24, 32'h1234_BEEF, 32'h0000_0000, 1'b0);
      table_q[9]  = make_vec(SH,  32'h26, 32'h0000_7A5C, 32'h0000_0000, 1'b0);
      table_q[10] = make_vec(LW,  32'h24, 32'h0000_0000, 32'h7A5C_BEEF, 1'b0);
      table_q[11] = make_vec(LB,  32'h23, 32'h0000_0000, 32'hFFFF_FF80, 1'b0);
      table_q[12] = make_vec(LBU, 32'h23, 32'h0000_0000, 32'h0000_0080, 1'b0);
      table_q[13] = make_vec(LB,  32'h21, 32'h0000_0000, 32'h0000_0055, 1'b0);
      table_q[14] = make_vec(LH,  32'h24, 32'h0000_0000, 32'hFFFF_BEEF, 1'b0);
      table_q[15] = make_vec(LHU, 32'h10, 32'h0000_0000, 32'h0000_4321, 1'b0);
      table_q[16] = make_vec(LH,  32'h26, 32'h0000_0000, 32'h0000_7A5C, 1'b0);
      table_q[17] = make_vec(LBU, 32'h12, 32'h0000_0000, 32'h0000_0065, 1'b0);
      table_q[18] = make_vec(LH,  32'h21, 32'h0000_0000, 32'h0000_0000, 1'b1);
      table_q[19] = make_vec(LW,  32'h22, 32'h0000_0000, 32'h0000_0000, 1'b1);
      table_q[20] = make_vec(SH,  32'h13, 32'h0000_FFFF, 32'h0000_0000, 1'b1);
      table_q[21] = make_vec(SW,  32'h11, 32'hDEAD_BEEF, 32'h0000_0000, 1'b1);
      table_q[22] = make_vec(LW,  32'h10, 32'h0000_0000, 32'h8765_4321, 1'b0);
      table_q[23] = make_vec(LHU, 32'h12, 32'h0000_0000, 32'h0000_8765, 1'b0);
   endtask

   task automatic send_req(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
      lsu_req_t r;
      r.op    = op;
      r.addr  = addr;
      r.wdata = wdata;
      while (o_busy) @(negedge i_clk);
      @(posedge i_clk);
      i_req_valid <= 1'b1;
      i_req       <= r;
      @(posedge i_clk);
      i_req_valid <= 1'b0;
   endtask

   // Offered well inside the init phase, so the DUT must drop it
   task automatic offer_while_busy(input lsu_req_t r);
      repeat (4) @(posedge i_clk);
      i_req_valid <= 1'b1;
      i_req       <= r;
      @(posedge i_clk);
      i_req_valid <= 1'b0;
   endtask

   task automatic wait_rsp(output lsu_rsp_t rsp);
      @(negedge i_clk);
      while (!o_rsp_valid) @(negedge i_clk);
      rsp = o_rsp;
   endtask

   // Busy covers the response cycle, then busy and the valid pulse both drop
   task automatic check_release(input string tag);
      checks++;
      if (o_busy !== 1'b1) begin
         $display("[ERROR] %s o_busy with response: expected 0x1, got 0x%0h", tag, o_busy);
         errors++;
      end
      @(negedge i_clk);
      if (o_busy !== 1'b0) begin
         $display("[ERROR] %s o_busy after response: expected 0x0, got 0x%0h", tag, o_busy);
         errors++;
      end
      if (o_rsp_valid !== 1'b0) begin
         $display("[ERROR] %s o_rsp_valid after response: expected 0x0, got 0x%0h",
                  tag, o_rsp_valid);
         errors++;
      end
   endtask

   task automatic check_rsp(input string tag, input lsu_rsp_t rsp,
                            input logic [31:0] exp_rdata, input logic exp_mis);
      checks++;
      if (rsp.rdata !== exp_rdata) begin
         $display("[ERROR] %s o_rsp.rdata: expected 0x%08h, got 0x%08h",
                  tag, exp_rdata, rsp.rdata);
         errors++;
      end
      if (rsp.misalign !== exp_mis) begin
         $display("[ERROR] %s o_rsp.misalign: expected 0x%0h, got 0x%0h",
                  tag, exp_mis, rsp.misalign);
         errors++;
      end
   endtask

   initial begin
      lsu_rsp_t    rsp;
      lsu_req_t    junk;
      mem_op_e     op;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] exp_rdata;
      logic        exp_mis;
      logic        offer;
      i_clk        = 1'b0;
      i_rst       <= 1'b1;
      i_req_valid <= 1'b0;
      i_req       <= '0;
      errors       = 0;
      checks       = 0;
      rng          = 32'd30455;
      for (int i = 0; i < RAM_BYTES; i++) begin
         model_mem[i] = 8'd0;
      end
      fill_table();

      repeat (2) @(posedge i_clk);
      i_rst <= 1'b0;
      @(negedge i_clk);
      checks++;
      if (o_busy !== 1'b0) begin
         $display("[ERROR] reset o_busy: expected 0x0, got 0x%0h", o_busy);
         errors++;
      end
      if (o_rsp_valid !== 1'b0) begin
         $display("[ERROR] reset o_rsp_valid: expected 0x0, got 0x%0h", o_rsp_valid);
         errors++;
      end

      for (int i = 0; i < N_TABLE; i++) begin
         // Model only tracks memory here, the table holds the expected values
         model_access(table_q[i].op, table_q[i].addr, table_q[i].wdata, exp_rdata, exp_mis);
         send_req(table_q[i].op, table_q[i].addr, table_q[i].wdata);
         wait_rsp(rsp);
         check_rsp($sformatf("table %0d", i), rsp, table_q[i].exp_rdata, table_q[i].exp_mis);
         check_release($sformatf("table %0d", i));
      end

      for (int i = 0; i < N_RANDOM; i++) begin
         rng  = xorshift32(rng);
         op   = mem_op_e'(rng[2:0]);
         addr = {24'd0, rng[15:8]};
         // Bias half the accesses toward word alignment
         if (rng[16]) begin
            addr[1:0] = 2'b00;
         end
         offer = (rng[20:19] == 2'b00);
         rng   = xorshift32(rng);
         wdata = rng;
         rng   = xorshift32(rng);
         junk.op    = SW;
         junk.addr  = {24'd0, rng[7:2], 2'b00};
         junk.wdata = ~wdata;
         model_access(op, addr, wdata, exp_rdata, exp_mis);
         send_req(op, addr, wdata);
         if (offer) begin
            offer_while_busy(junk);
         end
         wait_rsp(rsp);
         check_rsp($sformatf("random %0d", i), rsp, exp_rdata, exp_mis);
         check_release($sformatf("random %0d", i));
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
   parameter int RAM_WORDS = 64
) (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_req_valid,
   input  lsu_pkg::lsu_req_t i_req,
   output logic              o_busy,
   output logic              o_rsp_valid,
   output lsu_pkg::lsu_rsp_t o_rsp
);
   import lsu_pkg::*;

   logic                         en;
   logic                         init;
   logic                         trap;
   logic [1:0]                   bytecnt;
   logic [1:0]                   lsb;
   mem_op_e                      op;
   logic                         rs2;
   logic                         rd;
   logic                         misalign;
   logic [$clog2(RAM_WORDS)-1:0] adr;
   wb_req_t                      wb;
   logic [31:0]                  wb_rdt;
   logic                         wb_ack;

   lsu_sequencer #(.RAM_WORDS(RAM_WORDS)) u_seq (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_req_valid (i_req_valid),
      .i_req       (i_req),
      .i_rd        (rd),
      .i_misalign  (misalign),
      .i_wb_ack    (wb_ack),
      .o_busy      (o_busy),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp       (o_rsp),
      .o_en        (en),
      .o_init      (init),
      .o_trap      (trap),
      .o_bytecnt   (bytecnt),
      .o_lsb       (lsb),
      .o_op        (op),
      .o_rs2       (rs2),
      .o_adr       (adr)
   );

   lsu_mem_if u_mem_if (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_en       (en),
      .i_init     (init),
      .i_op       (op),
      .i_bytecnt  (bytecnt),
      .i_lsb      (lsb),
      .i_rs2      (rs2),
      .i_trap     (trap),
      .i_wb_rdt   (wb_rdt),
      .i_wb_ack   (wb_ack),
      .o_rd       (rd),
      .o_misalign (misalign),
      .o_wb       (wb)
   );

   lsu_data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wb     (wb),
      .i_adr    (adr),
      .o_wb_rdt (wb_rdt),
      .o_wb_ack (wb_ack)
   );

endmodule

`default_nettype wire

//--- logic/lsu_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_data_ram #(
   parameter int RAM_WORDS = 64
) (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  lsu_pkg::wb_req_t             i_wb,
   input  logic [$clog2(RAM_WORDS)-1:0] i_adr,
   output logic [31:0]                  o_wb_rdt,
   output logic                         o_wb_ack
);

   logic [31:0] mem [RAM_WORDS];
   logic        access;

   // Memory contents start cleared
   initial begin
      for (int i = 0; i < RAM_WORDS; i++) begin
         mem[i] = 32'd0;
      end
   end

   // One access per cycle request, answered on the following edge
   assign access = i_wb.cyc & ~o_wb_ack;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_wb_ack <= 1'b0;
      end else begin
         o_wb_ack <= access;
      end
   end

   always_ff @(posedge i_clk) begin
      if (access) begin
         if (i_wb.we) begin
            for (int b = 0; b < 4; b++) begin
               if (i_wb.sel[b]) begin
                  mem[i_adr][8*b +: 8] <= i_wb.dat[8*b +: 8];
               end
            end
         end
         o_wb_rdt <= mem[i_adr];
      end
   end

   a_ack_within_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
      o_wb_ack |-> i_wb.cyc);

endmodule

`default_nettype wire

//--- logic/lsu_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_if (
   input  logic             i_clk,
   input  logic             i_rst,
   input  logic             i_en,
   input  logic             i_init,
   input  lsu_pkg::mem_op_e i_op,
   input  logic [1:0]       i_bytecnt,
   input  logic [1:0]       i_lsb,
   input  logic             i_rs2,
   input  logic             i_trap,
   input  logic [31:0]      i_wb_rdt,
   input  logic             i_wb_ack,
   output logic             o_rd,
   output logic             o_misalign,
   output lsu_pkg::wb_req_t o_wb
);
   import lsu_pkg::*;

   logic [1:0]      width;
   logic            is_signed;
   logic [3:0][7:0] lane;
   logic [3:0]      lane_en;
   logic [3:0]      wr_lane;
   logic [1:0]      bytepos;
   logic [1:0]      rd_sel;
   logic            rd_cur;
   logic            rd_valid;
   logic            sign_bit;
   logic            init_q;
   logic            cyc_r;
   logic            wb_done;
   logic [3:0]      sel;

   assign width     = mem_op_width(i_op);
   assign is_signed = (i_op == LB) || (i_op == LH);
   assign wb_done   = cyc_r & i_wb_ack;

   // Upper byte counts map straight to lanes, lower ones are offset by the address
   assign rd_sel   = i_bytecnt[1] ? i_bytecnt : (i_bytecnt | bytepos);
   assign rd_cur   = lane[rd_sel][0];
   assign rd_valid = (width == W_WORD) || (i_bytecnt == 2'd0) ||
                     ((width == W_HALF) && !i_bytecnt[1]);

   // Past the valid bits repeat the sign, or zero for unsigned loads
   assign o_rd = rd_valid ? rd_cur : (sign_bit & is_signed);

   // Byte 0 lands in every lane, byte 1 also in lane 3 for upper halfwords
   assign wr_lane[0] = (i_bytecnt == 2'd0);
   assign wr_lane[1] = (i_bytecnt == 2'd0) || ((i_bytecnt == 2'd1) && !bytepos[0]);
   assign wr_lane[2] = (i_bytecnt == 2'd0) || ((i_bytecnt == 2'd2) && !bytepos[1]);
   assign wr_lane[3] = (i_bytecnt == 2'd0) || ((i_bytecnt == 2'd1) && !bytepos[0]) ||
                       ((i_bytecnt == 2'd3) && !bytepos[1]);

   always_comb begin
      for (int i = 0; i < 4; i++) begin
         lane_en[i] = i_en & (i_init ? wr_lane[i] : (rd_sel == 2'(i)));
      end
   end

   always_comb begin
      case (width)
         W_WORD:  sel = 4'b1111;
         W_HALF:  sel = bytepos[1] ? 4'b1100 : 4'b0011;
         default: sel = 4'b0001 << bytepos;
      endcase
   end

   assign o_wb.dat = lane;
   assign o_wb.sel = sel;
   assign o_wb.we  = mem_op_is_store(i_op);
   assign o_wb.cyc = cyc_r;

   always_ff @(posedge i_clk) begin
      if (i_init) begin
         bytepos <= i_lsb;
      end
      if (wb_done) begin
         lane <= i_wb_rdt;
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (lane_en[i]) begin
               lane[i] <= {i_rs2, lane[i][7:1]};
            end
         end
      end
      if (rd_valid) begin
         sign_bit <= rd_cur;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         init_q     <= 1'b0;
         cyc_r      <= 1'b0;
         o_misalign <= 1'b0;
      end else begin
         init_q     <= i_init;
         o_misalign <= i_en & ((bytepos[0] & (width != W_BYTE)) |
                               (bytepos[1] & (width == W_WORD)));
         // Bus cycle opens once init has ended, unless trapped
         if (wb_done) begin
            cyc_r <= 1'b0;
         end else if (init_q && !i_init && !i_trap) begin
            cyc_r <= 1'b1;
         end
      end
   end

   a_no_cyc_during_init: assert property (@(posedge i_clk) disable iff (i_rst)
      $rose(cyc_r) |-> !i_init);

endmodule

`default_nettype wire

//--- logic/lsu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_sequencer #(
   parameter int RAM_WORDS = 64
) (
   input  logic                           i_clk,
   input  logic                           i_rst,
   input  logic                           i_req_valid,
   input  lsu_pkg::lsu_req_t              i_req,
   input  logic                           i_rd,
   input  logic                           i_misalign,
   input  logic                           i_wb_ack,
   output logic                           o_busy,
   output logic                           o_rsp_valid,
   output lsu_pkg::lsu_rsp_t              o_rsp,
   output logic                           o_en,
   output logic                           o_init,
   output logic                           o_trap,
   output logic [1:0]                     o_bytecnt,
   output logic [1:0]                     o_lsb,
   output lsu_pkg::mem_op_e               o_op,
   output logic                           o_rs2,
   output logic [$clog2(RAM_WORDS)-1:0]   o_adr
);
   import lsu_pkg::*;

   localparam int AW = $clog2(RAM_WORDS);

   seq_state_e  state;
   logic [4:0]  cnt;
   logic        en_r;
   logic        init_r;
   logic        trap_r;
   logic        accept;
   lsu_req_t    req_r;
   logic [31:0] rdata_r;

   assign accept = (state == IDLE) && i_req_valid;

   assign o_busy      = (state != IDLE);
   assign o_rsp_valid = (state == DONE);
   assign o_en        = en_r;
   assign o_init      = init_r;
   assign o_trap      = trap_r;
   assign o_bytecnt   = cnt[4:3];
   assign o_lsb       = req_r.addr[1:0];
   assign o_op        = req_r.op;
   assign o_adr       = req_r.addr[AW+1:2];

   // Store data leaves LSB first
   assign o_rs2 = req_r.wdata[0];

   // Result stays zero unless a read phase ran
   assign o_rsp.rdata    = rdata_r;
   assign o_rsp.misalign = trap_r;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state  <= IDLE;
         cnt    <= 5'd0;
         en_r   <= 1'b0;
         init_r <= 1'b0;
         trap_r <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (i_req_valid) begin
                  state  <= INIT;
                  cnt    <= 5'd0;
                  en_r   <= 1'b1;
                  init_r <= 1'b1;
                  trap_r <= 1'b0;
               end
            end
            INIT: begin
               cnt <= cnt + 5'd1;
               if (cnt == 5'd31) begin
                  en_r   <= 1'b0;
                  init_r <= 1'b0;
                  // Misaligned access skips the bus entirely
                  trap_r <= i_misalign;
                  state  <= i_misalign ? DONE : BUS;
               end
            end
            BUS: begin
               if (i_wb_ack) begin
                  if (mem_op_is_store(req_r.op)) begin
                     state <= DONE;
                  end else begin
                     state <= READ;
                     en_r  <= 1'b1;
                  end
               end
            end
            READ: begin
               cnt <= cnt + 5'd1;
               if (cnt == 5'd31) begin
                  en_r  <= 1'b0;
                  state <= DONE;
               end
            end
            DONE: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Request payload and load result
   always_ff @(posedge i_clk) begin
      if (accept) begin
         req_r   <= i_req;
         rdata_r <= 32'd0;
      end else if (state == INIT) begin
         req_r.wdata <= {1'b0, req_r.wdata[31:1]};
      end
      if (state == READ) begin
         rdata_r <= {i_rd, rdata_r[31:1]};
      end
   end

   a_en_in_serial_phase: assert property (@(posedge i_clk) disable iff (i_rst)
      en_r |-> (state inside {INIT, READ}));

   a_no_ack_in_idle: assert property (@(posedge i_clk) disable iff (i_rst)
      i_wb_ack |-> (state != IDLE));

endmodule

`default_nettype wire

//--- logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

   // Loads keep their funct3 code, stores fill the unused slots
   typedef enum logic [2:0] {
      LB  = 3'd0,
      LH  = 3'd1,
      LW  = 3'd2,
      SB  = 3'd3,
      LBU = 3'd4,
      LHU = 3'd5,
      SH  = 3'd6,
      SW  = 3'd7
   } mem_op_e;

   typedef enum logic [2:0] {
      IDLE,
      INIT,
      BUS,
      READ,
      DONE
   } seq_state_e;

   // Access width codes
   localparam logic [1:0] W_BYTE = 2'd0;
   localparam logic [1:0] W_HALF = 2'd1;
   localparam logic [1:0] W_WORD = 2'd2;

   typedef struct packed {
      mem_op_e     op;
      logic [31:0] addr;
      logic [31:0] wdata;
   } lsu_req_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        misalign;
   } lsu_rsp_t;

   typedef struct packed {
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
      logic        cyc;
   } wb_req_t;

   function automatic logic mem_op_is_store(mem_op_e op);
      return (op == SB) || (op == SH) || (op == SW);
   endfunction

   function automatic logic [1:0] mem_op_width(mem_op_e op);
      case (op)
         LB, LBU, SB: return W_BYTE;
         LH, LHU, SH: return W_HALF;
         default:     return W_WORD;
      endcase
   endfunction

endpackage

`default_nettype wire
